// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////
	// Sizing
	localparam int kInstDepth = 4;	// Ingress slots, equals sender credits
	localparam int kResCredits = 4;	// Result credits after reset
	localparam int kMemWords = 64;	// Data memory depth
	localparam int kInstPtrW = $clog2(kInstDepth);
	localparam int kCreditW = $clog2(kResCredits + 1);
	localparam int kMemAddrW = $clog2(kMemWords);	// Word index bits

	////////////////////
	// Opcodes
	localparam logic [5:0] kOpRType = 6'h00;
	localparam logic [5:0] kOpBeq = 6'h04;
	localparam logic [5:0] kOpBne = 6'h05;
	localparam logic [5:0] kOpAddi = 6'h08;
	localparam logic [5:0] kOpSlti = 6'h0A;
	localparam logic [5:0] kOpAndi = 6'h0C;
	localparam logic [5:0] kOpOri = 6'h0D;
	localparam logic [5:0] kOpXori = 6'h0E;
	localparam logic [5:0] kOpLui = 6'h0F;
	localparam logic [5:0] kOpLb = 6'h20;
	localparam logic [5:0] kOpLh = 6'h21;
	localparam logic [5:0] kOpLw = 6'h23;
	localparam logic [5:0] kOpLbu = 6'h24;
	localparam logic [5:0] kOpLhu = 6'h25;
	localparam logic [5:0] kOpLwu = 6'h27;
	localparam logic [5:0] kOpSb = 6'h28;
	localparam logic [5:0] kOpSh = 6'h29;
	localparam logic [5:0] kOpSw = 6'h2B;
	localparam logic [5:0] kOpFinish = 6'h3E;
	localparam logic [5:0] kOpEnd = 6'h3F;	// Halts issue once retired

	// R-type funct field
	localparam logic [5:0] kFnSll = 6'h00;
	localparam logic [5:0] kFnSrl = 6'h02;
	localparam logic [5:0] kFnSra = 6'h03;
	localparam logic [5:0] kFnSllv = 6'h04;
	localparam logic [5:0] kFnSrlv = 6'h06;
	localparam logic [5:0] kFnSrav = 6'h07;
	localparam logic [5:0] kFnAdd = 6'h20;
	localparam logic [5:0] kFnSub = 6'h22;
	localparam logic [5:0] kFnAnd = 6'h24;
	localparam logic [5:0] kFnOr = 6'h25;
	localparam logic [5:0] kFnXor = 6'h26;
	localparam logic [5:0] kFnNor = 6'h27;
	localparam logic [5:0] kFnSlt = 6'h2A;

	////////////////////
	// Types
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluXor = 4'd4,
		aluNor = 4'd5,
		aluSll = 4'd6,
		aluSrl = 4'd7,
		aluSra = 4'd8,
		aluSlt = 4'd9	// Signed compare
	} aluOp_t;

	typedef enum logic [1:0] {
		srcReg = 2'd0,	// Register B
		srcImm = 2'd1,	// Sign-extended immediate
		srcShamt = 2'd2,	// Shift by inst[10:6]
		srcLui = 2'd3	// Immediate to upper half
	} aluSrc_t;

	typedef enum logic [1:0] {
		sizeWord = 2'd0,
		sizeByte = 2'd1,
		sizeHalf = 2'd2
	} memSize_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instWord_t;

	typedef struct packed {
		aluOp_t aluOp;
		aluSrc_t aluSrc;
		logic regWrite;
		logic memToReg;	// Writeback from memory
		logic [3:0] byteEn;	// Store lanes before offset shift
		memSize_t readSize;
		logic readSigned;
		logic branch;
		logic branchNe;	// BNE when set
		logic regDst;	// Dest is rd, else rt
		logic isFinal;	// END marker
	} ctrl_t;

	typedef struct packed {
		logic regWrite;
		logic [4:0] destReg;
		logic [31:0] value;	// Store address for stores
		logic isBranch;
		logic taken;
		logic isStore;
	} resRec_t;

endpackage

`default_nettype wire

// File: src/creditFifo.sv
`timescale 1ns/1ps
`default_nettype none

module creditFifo (
	input wire clk,
	input wire rst,
	input wire pushValid,
	input wire mipsPkg::instWord_t pushData,
	input wire pop,
	output mipsPkg::instWord_t headData,
	output logic notEmpty,
	output logic credit
);
	import mipsPkg::*;

	instWord_t slots [kInstDepth];	// Circular storage
	logic [kInstPtrW-1:0] wrPtr;
	logic [kInstPtrW-1:0] rdPtr;
	logic [kInstPtrW:0] count;	// Occupancy 0..depth
	logic full;
	logic doPush;
	logic doPop;

	assign full = (count == (kInstPtrW + 1)'(kInstDepth));
	assign notEmpty = (count != '0);
	assign doPush = pushValid && !full;
	assign doPop = pop && notEmpty;
	assign headData = slots[rdPtr];	// Head visible without a pop

	always_ff @(posedge clk)
	begin
		if (doPush)
			slots[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// Power-of-two wrap
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
			credit <= doPop;	// One credit back per pop
		end
	end

	// Sender must never outrun its credits
	assert property (@(posedge clk) disable iff (rst) pushValid |-> !full)
		else $error("creditFifo push while full");

endmodule

`default_nettype wire

// File: src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire mipsPkg::instWord_t inst,
	output mipsPkg::ctrl_t ctrl
);
	import mipsPkg::*;

	always_comb
	begin
		ctrl = '0;	// Unknown ops and FINISH stay all zero
		case (inst.op)
			kOpRType:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;	// Writes rd
				case (inst.funct)
					kFnAdd: ctrl.aluOp = aluAdd;
					kFnSub: ctrl.aluOp = aluSub;
					kFnAnd: ctrl.aluOp = aluAnd;
					kFnOr: ctrl.aluOp = aluOr;
					kFnXor: ctrl.aluOp = aluXor;
					kFnNor: ctrl.aluOp = aluNor;
					kFnSlt: ctrl.aluOp = aluSlt;
					kFnSllv: ctrl.aluOp = aluSll;	// Amount from rs
					kFnSrlv: ctrl.aluOp = aluSrl;
					kFnSrav: ctrl.aluOp = aluSra;
					kFnSll:
					begin
						ctrl.aluOp = aluSll;
						ctrl.aluSrc = srcShamt;	// Amount from inst[10:6]
					end
					kFnSrl:
					begin
						ctrl.aluOp = aluSrl;
						ctrl.aluSrc = srcShamt;
					end
					kFnSra:
					begin
						ctrl.aluOp = aluSra;
						ctrl.aluSrc = srcShamt;
					end
					default: ctrl = '0;	// Unsupported funct
				endcase
			end
			kOpLb, kOpLbu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = srcImm;	// Base plus offset
				ctrl.readSize = sizeByte;
				ctrl.readSigned = (inst.op == kOpLb);	// LBU zero-extends
			end
			kOpLh, kOpLhu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = srcImm;
				ctrl.readSize = sizeHalf;
				ctrl.readSigned = (inst.op == kOpLh);
			end
			kOpLw, kOpLwu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = srcImm;
				ctrl.readSize = sizeWord;	// Full word either way
			end
			kOpSb:
			begin
				ctrl.aluSrc = srcImm;
				ctrl.byteEn = 4'b0001;	// One lane
			end
			kOpSh:
			begin
				ctrl.aluSrc = srcImm;
				ctrl.byteEn = 4'b0011;	// Two lanes
			end
			kOpSw:
			begin
				ctrl.aluSrc = srcImm;
				ctrl.byteEn = 4'b1111;
			end
			kOpAddi, kOpAndi, kOpOri, kOpXori, kOpSlti:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = srcImm;
				case (inst.op)
					kOpAndi: ctrl.aluOp = aluAnd;
					kOpOri: ctrl.aluOp = aluOr;
					kOpXori: ctrl.aluOp = aluXor;
					kOpSlti: ctrl.aluOp = aluSlt;
					default: ctrl.aluOp = aluAdd;	// ADDI
				endcase
			end
			kOpLui:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = srcLui;
				ctrl.aluOp = aluSll;	// Immediate shifted by 16
			end
			kOpBeq, kOpBne:
			begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = aluSub;	// Zero flag on equality
				ctrl.branchNe = (inst.op == kOpBne);
			end
			kOpEnd: ctrl.isFinal = 1'b1;
			kOpFinish: ctrl = '0;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire clk,
	input wire rst,
	input wire [4:0] rdAddrA,
	input wire [4:0] rdAddrB,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB,
	input wire wrEn,
	input wire [4:0] wrAddr,
	input wire [31:0] wrData
);

	logic [31:0] regs [32];

	// Async read ports, r0 forced to zero
	assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end
		else if (wrEn && (wrAddr != 5'd0))
		begin
			regs[wrAddr] <= wrData;	// Commits at end of stage 2
		end
	end

endmodule

`default_nettype wire

// File: src/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input wire mipsPkg::aluOp_t aluOp,
	input wire mipsPkg::aluSrc_t aluSrc,
	input wire [31:0] regA,
	input wire [31:0] regB,
	input wire [15:0] imm,
	input wire [4:0] shamt,
	output logic [31:0] result,
	output logic zero
);
	import mipsPkg::*;

	logic [31:0] opB;	// Second arithmetic operand
	logic [31:0] shVal;	// Value being shifted
	logic [4:0] shAmt;

	always_comb
	begin
		opB = regB;
		shVal = regB;	// rt is shifted
		shAmt = regA[4:0];	// Variable shift amount
		case (aluSrc)
			srcImm: opB = {{16{imm[15]}}, imm};
			srcShamt: shAmt = shamt;
			srcLui:
			begin
				shVal = {16'h0000, imm};
				shAmt = 5'd16;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		result = 32'd0;
		case (aluOp)
			aluAdd: result = regA + opB;
			aluSub: result = regA - opB;
			aluAnd: result = regA & opB;
			aluOr: result = regA | opB;
			aluXor: result = regA ^ opB;
			aluNor: result = ~(regA | opB);
			aluSll: result = shVal << shAmt;
			aluSrl: result = shVal >> shAmt;
			aluSra: result = $signed(shVal) >>> shAmt;	// Sign fill
			aluSlt: result = {31'd0, $signed(regA) < $signed(opB)};
			default: result = 32'd0;
		endcase
	end

	assign zero = (result == 32'd0);	// Branch compare

endmodule

`default_nettype wire

// File: src/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem (
	input wire clk,
	input wire rst,
	input wire [31:0] addr,
	input wire [31:0] wrData,
	input wire [3:0] byteEn,
	input wire mipsPkg::memSize_t readSize,
	input wire readSigned,
	output logic [31:0] rdData
);
	import mipsPkg::*;

	logic [31:0] mem [kMemWords];
	logic [kMemAddrW-1:0] wordIdx;
	logic [1:0] off;	// Byte offset in word
	logic [3:0] wrLanes;
	logic [31:0] wrShifted;
	logic [31:0] rdWord;
	logic [31:0] lane;	// Addressed byte moved to bit 0

	assign wordIdx = addr[kMemAddrW+1:2];	// Wraps modulo memory size
	assign off = addr[1:0];
	assign wrLanes = byteEn << off;	// Lanes past bit 3 drop
	assign wrShifted = wrData << {off, 3'b000};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int w = 0; w < kMemWords; w++)
				mem[w] <= 32'd0;
		end
		else
		begin
			for (int b = 0; b < 4; b++)
				if (wrLanes[b])
					mem[wordIdx][8*b +: 8] <= wrShifted[8*b +: 8];
		end
	end

	////////////////////
	// Sized read
	assign rdWord = mem[wordIdx];
	assign lane = rdWord >> {off, 3'b000};

	always_comb
	begin
		case (readSize)
			sizeByte: rdData = {{24{readSigned & lane[7]}}, lane[7:0]};
			sizeHalf: rdData = {{16{readSigned & lane[15]}}, lane[15:0]};
			default: rdData = rdWord;	// Word ignores offset
		endcase
	end

endmodule

`default_nettype wire

// File: src/execPipe.sv
`timescale 1ns/1ps
`default_nettype none

module execPipe (
	input wire clk,
	input wire rst,
	input wire mipsPkg::instWord_t headData,
	input wire notEmpty,
	input wire halted,
	output logic pop,
	input wire resCredit,
	output logic resValid,
	output mipsPkg::resRec_t resOut,
	output logic retireFinal
);
	import mipsPkg::*;

	logic [kCreditW-1:0] credits;	// Result credits left
	logic s1Valid;
	instWord_t s1Inst;
	ctrl_t s1Ctrl;
	logic [31:0] rfA;
	logic [31:0] rfB;
	logic [31:0] fwdA;
	logic [31:0] fwdB;
	logic s2Valid;
	ctrl_t s2Ctrl;
	logic [31:0] s2A;
	logic [31:0] s2B;
	logic [15:0] s2Imm;
	logic [4:0] s2Dest;
	logic [31:0] aluResult;
	logic aluZero;
	logic [31:0] memData;
	logic [31:0] wbValue;
	logic s2Writes;

	assign pop = notEmpty && (credits != '0) && !halted;	// Issue rule

	////////////////////
	// Stage 1 decode and read
	controlUnit uCtrl (.inst(s1Inst), .ctrl(s1Ctrl));

	regFile uRegs (
		.clk(clk), .rst(rst),
		.rdAddrA(s1Inst.rs), .rdAddrB(s1Inst.rt),
		.rdDataA(rfA), .rdDataB(rfB),
		.wrEn(s2Writes), .wrAddr(s2Dest), .wrData(wbValue)
	);

	// Stage 2 result overrides stale register data
	assign s2Writes = s2Valid && s2Ctrl.regWrite;
	assign fwdA = (s2Writes && s2Dest != 5'd0 && s2Dest == s1Inst.rs) ? wbValue : rfA;
	assign fwdB = (s2Writes && s2Dest != 5'd0 && s2Dest == s1Inst.rt) ? wbValue : rfB;

	always_ff @(posedge clk)
	begin
		s1Inst <= headData;
		s2Ctrl <= s1Ctrl;
		s2A <= fwdA;
		s2B <= fwdB;	// Also store data
		s2Imm <= {s1Inst.rd, s1Inst.shamt, s1Inst.funct};
		s2Dest <= s1Ctrl.regDst ? s1Inst.rd : s1Inst.rt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end
		else
		begin
			s1Valid <= pop;
			s2Valid <= s1Valid;	// No stall between stages
		end
	end

	////////////////////
	// Stage 2 execute, memory, writeback
	aluUnit uAlu (
		.aluOp(s2Ctrl.aluOp), .aluSrc(s2Ctrl.aluSrc),
		.regA(s2A), .regB(s2B), .imm(s2Imm), .shamt(s2Imm[10:6]),
		.result(aluResult), .zero(aluZero)
	);

	dataMem uMem (
		.clk(clk), .rst(rst), .addr(aluResult), .wrData(s2B),
		.byteEn(s2Valid ? s2Ctrl.byteEn : 4'b0000),
		.readSize(s2Ctrl.readSize), .readSigned(s2Ctrl.readSigned),
		.rdData(memData)
	);

	assign wbValue = s2Ctrl.memToReg ? memData : aluResult;	// Address for stores

	assign resValid = s2Valid;
	assign resOut.regWrite = s2Ctrl.regWrite;
	assign resOut.destReg = s2Dest;
	assign resOut.value = wbValue;
	assign resOut.isBranch = s2Ctrl.branch;
	assign resOut.taken = s2Ctrl.branch && (s2Ctrl.branchNe ? !aluZero : aluZero);
	assign resOut.isStore = |s2Ctrl.byteEn;
	assign retireFinal = s2Valid && s2Ctrl.isFinal;

	// Spend on issue, regain on receiver credit
	always_ff @(posedge clk)
	begin
		if (rst)
			credits <= kCreditW'(kResCredits);
		else
		begin
			case ({pop, resCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Receiver returns no more credits than records sent
	assert property (@(posedge clk) disable iff (rst) credits <= kCreditW'(kResCredits))
		else $error("execPipe result credits above limit");

endmodule

`default_nettype wire

// File: src/statusRegs.sv
`timescale 1ns/1ps
`default_nettype none

module statusRegs (
	input wire clk,
	input wire rst,
	input wire retireValid,
	input wire retireFinal,
	output logic halted,
	output logic [15:0] retiredCount
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			halted <= 1'b0;
			retiredCount <= 16'd0;
		end
		else
		begin
			if (retireValid)
				retiredCount <= retiredCount + 16'd1;	// END counts too
			if (retireFinal)
				halted <= 1'b1;	// Sticky until reset
		end
	end

	// Halt only follows a retirement
	assert property (@(posedge clk) disable iff (rst) $rose(halted) |-> $past(retireValid))
		else $error("statusRegs halted without END retirement");

endmodule

`default_nettype wire

// File: src/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop (
	input wire clk,
	input wire rst,
	input wire instValid,
	input wire mipsPkg::instWord_t instIn,
	output logic instCredit,
	output logic resValid,
	output mipsPkg::resRec_t resOut,
	input wire resCredit,
	output logic halted,
	output logic [15:0] retiredCount
);
	import mipsPkg::*;

	instWord_t headData;	// Queue head to stage 1
	logic notEmpty;
	logic pop;
	logic retireFinal;	// END in stage 2

	////////////////////
	// Ingress queue
	creditFifo uFifo (
		.clk(clk),
		.rst(rst),
		.pushValid(instValid),
		.pushData(instIn),
		.pop(pop),
		.headData(headData),
		.notEmpty(notEmpty),
		.credit(instCredit)
	);

	execPipe uPipe (
		.clk(clk),
		.rst(rst),
		.headData(headData),
		.notEmpty(notEmpty),
		.halted(halted),	// Gates issue
		.pop(pop),
		.resCredit(resCredit),
		.resValid(resValid),
		.resOut(resOut),
		.retireFinal(retireFinal)
	);

	statusRegs uStatus (
		.clk(clk),
		.rst(rst),
		.retireValid(resValid),
		.retireFinal(retireFinal),
		.halted(halted),
		.retiredCount(retiredCount)
	);

endmodule

`default_nettype wire

// File: bench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Architectural state, updated in program order
logic [31:0] modelRegs [32];
logic [7:0] modelMem [256];	// Byte array, 64 words little-endian

task automatic modelClear();
	for (int k = 0; k < 32; k++)
		modelRegs[k] = 32'd0;
	for (int k = 0; k < 256; k++)
		modelMem[k] = 8'd0;
endtask

// Gather count bytes from addr upward, then extend
function automatic logic [31:0] readModelBytes(input logic [7:0] addr, input int count,
	input logic signExt);
	logic [31:0] v;
	v = 32'd0;
	for (int k = 0; k < count; k++)
		v[8*k +: 8] = modelMem[8'(addr + k)];
	if (signExt && count < 4 && v[8*count-1])
		v = v | (32'hFFFF_FFFF << (8 * count));	// Fill upper bytes
	return v;
endfunction

task automatic writeModelBytes(input logic [7:0] addr, input logic [31:0] data, input int count);
	for (int k = 0; k < count; k++)
		modelMem[8'(addr + k)] = data[8*k +: 8];	// Low bytes of rt
endtask

// Executes one instruction and predicts its result record
task automatic modelExec(input instWord_t inst, output resRec_t rec);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] res;
	logic [15:0] imm;
	a = modelRegs[inst.rs];
	b = modelRegs[inst.rt];
	imm = {inst.rd, inst.shamt, inst.funct};
	simm = {{16{imm[15]}}, imm};
	res = 32'd0;
	rec = '0;
	rec.destReg = inst.rt;	// I-type target
	case (inst.op)
		kOpRType:
		begin
			rec.regWrite = 1'b1;
			rec.destReg = inst.rd;
			case (inst.funct)
				kFnAdd: res = a + b;
				kFnSub: res = a - b;
				kFnAnd: res = a & b;
				kFnOr: res = a | b;
				kFnXor: res = a ^ b;
				kFnNor: res = ~(a | b);
				kFnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				kFnSll: res = b << inst.shamt;
				kFnSrl: res = b >> inst.shamt;
				kFnSra: res = $signed(b) >>> inst.shamt;
				kFnSllv: res = b << a[4:0];	// Amount from rs
				kFnSrlv: res = b >> a[4:0];
				kFnSrav: res = $signed(b) >>> a[4:0];
				default: rec.regWrite = 1'b0;
			endcase
		end
		kOpAddi: res = a + simm;
		kOpAndi: res = a & simm;	// Immediate sign-extended here too
		kOpOri: res = a | simm;
		kOpXori: res = a ^ simm;
		kOpSlti: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
		kOpLui: res = {imm, 16'h0000};
		kOpLb: res = readModelBytes(8'(a + simm), 1, 1'b1);
		kOpLbu: res = readModelBytes(8'(a + simm), 1, 1'b0);
		kOpLh: res = readModelBytes(8'(a + simm), 2, 1'b1);
		kOpLhu: res = readModelBytes(8'(a + simm), 2, 1'b0);
		kOpLw, kOpLwu: res = readModelBytes(8'(a + simm), 4, 1'b0);
		kOpSb, kOpSh, kOpSw:
		begin
			res = a + simm;	// Full address reported
			rec.isStore = 1'b1;
			writeModelBytes(8'(res), b, (inst.op == kOpSb) ? 1 : (inst.op == kOpSh) ? 2 : 4);
		end
		kOpBeq, kOpBne:
		begin
			rec.isBranch = 1'b1;
			rec.taken = (inst.op == kOpBeq) ? (a == b) : (a != b);
		end
		default: ;	// END, FINISH and unknown ops
	endcase
	case (inst.op)
		kOpAddi, kOpAndi, kOpOri, kOpXori, kOpSlti, kOpLui: rec.regWrite = 1'b1;
		kOpLb, kOpLbu, kOpLh, kOpLhu, kOpLw, kOpLwu: rec.regWrite = 1'b1;
		default: ;
	endcase
	rec.value = res;
	if (rec.regWrite && rec.destReg != 5'd0)
		modelRegs[rec.destReg] = res;	// r0 stays zero
endtask

`endif

// File: bench/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;
	import mipsPkg::*;

	logic clk;
	logic rst;
	logic instValid;
	instWord_t instIn;
	logic instCredit;
	logic resValid;
	resRec_t resOut;
	logic resCredit;
	logic halted;
	logic [15:0] retiredCount;

	int sendCredits;	// Sender side ingress credits
	int instCreditCount;
	int recordCount;
	int creditsBack;	// Result credits handed back
	int cycleNo;
	int lastRelease;
	int delayTable [64];	// Sink credit delays, 0..3 cycles
	logic holdCredits;	// Sink withholds credits
	logic quietWindow;
	logic nextCredit;
	logic prevInstCredit;
	instWord_t sentQ [$];	// Sent, not yet retired
	int releaseQ [$];	// Cycle each credit goes back

	`include "refModel.svh"

	coreTop dut (
		.clk(clk),
		.rst(rst),
		.instValid(instValid),
		.instIn(instIn),
		.instCredit(instCredit),
		.resValid(resValid),
		.resOut(resOut),
		.resCredit(resCredit),
		.halted(halted),
		.retiredCount(retiredCount)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	////////////////////
	// Checking helpers
	task automatic abortRun();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic stopOnError(input string why);
		$display("%s", why);
		abortRun();
	endtask

	task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, want);
			abortRun();
		end
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#2;	// Drive point
	endtask

	////////////////////
	// Stimulus builders
	function automatic instWord_t makeR(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		instWord_t m;
		m.op = kOpRType;
		m.rs = rs;
		m.rt = rt;
		m.rd = rd;
		m.shamt = sh;
		m.funct = fn;
		return m;
	endfunction

	function automatic instWord_t makeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instWord_t m;
		m.op = op;
		m.rs = rs;
		m.rt = rt;
		{m.rd, m.shamt, m.funct} = imm;
		return m;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'($urandom_range(7, 0));	// Small set, frequent dependencies
	endfunction

	function automatic instWord_t randAluInst();
		int pick;
		logic [5:0] code;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		pick = $urandom_range(18, 0);
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		imm = 16'($urandom);
		case (pick)
			0: code = kFnAdd;
			1: code = kFnSub;
			2: code = kFnAnd;
			3: code = kFnOr;
			4: code = kFnXor;
			5: code = kFnNor;
			6: code = kFnSlt;
			7: code = kFnSll;
			8: code = kFnSrl;
			9: code = kFnSra;
			10: code = kFnSllv;
			11: code = kFnSrlv;
			12: code = kFnSrav;
			13: code = kOpAddi;
			14: code = kOpAndi;
			15: code = kOpOri;
			16: code = kOpXori;
			17: code = kOpSlti;
			default: code = kOpLui;
		endcase
		if (pick < 13)
			return makeR(code, rs, rt, rd, imm[4:0]);
		else
			return makeI(code, rs, rt, imm);
	endfunction

	////////////////////
	// Sender and sink
	task automatic sendInst(input instWord_t inst);
		int waited;
		waited = 0;
		while (sendCredits == 0)
		begin
			stepCycle();
			waited++;
			if (waited > 200)
				stopOnError("Sender stalled, no ingress credit came back");
		end
		instValid = 1'b1;
		instIn = inst;
		sendCredits--;
		sentQ.push_back(inst);
		stepCycle();
		instValid = 1'b0;
	endtask

	task automatic checkRecord();
		instWord_t inst;
		resRec_t want;
		int rel;
		if (quietWindow)
			stopOnError("Record retired after halt, issue did not stop");
		if (sentQ.size() == 0)
			stopOnError("Record retired with no instruction outstanding");
		inst = sentQ.pop_front();
		modelExec(inst, want);
		checkEqual("resOut.regWrite", resOut.regWrite, want.regWrite);
		checkEqual("resOut.isBranch", resOut.isBranch, want.isBranch);
		checkEqual("resOut.taken", resOut.taken, want.taken);
		checkEqual("resOut.isStore", resOut.isStore, want.isStore);
		if (want.regWrite)
			checkEqual("resOut.destReg", resOut.destReg, want.destReg);
		if (want.regWrite || want.isStore)
			checkEqual("resOut.value", resOut.value, want.value);
		rel = cycleNo + 1 + delayTable[recordCount % 64];
		if (rel <= lastRelease)
			rel = lastRelease + 1;	// One credit per cycle
		lastRelease = rel;
		releaseQ.push_back(rel);
		recordCount++;
		if (recordCount - creditsBack > kResCredits)
			stopOnError("More records outstanding than result credits");
	endtask

	// Outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (rst)
			nextCredit = 1'b0;
		else
		begin
			cycleNo++;
			checkEqual("resValid", resValid, prevInstCredit);	// Credit at pop+1, record at pop+2
			prevInstCredit = instCredit;
			if (instCredit)
			begin
				sendCredits++;
				instCreditCount++;
			end
			if (resValid)
				checkRecord();
			if (!holdCredits && releaseQ.size() != 0 && releaseQ[0] <= cycleNo + 1)
			begin
				nextCredit = 1'b1;	// Pulse next cycle
				void'(releaseQ.pop_front());
				creditsBack++;
			end
			else
				nextCredit = 1'b0;
		end
	end

	initial
	begin
		resCredit = 1'b0;
		forever
		begin
			@(posedge clk);
			#2;
			resCredit = rst ? 1'b0 : nextCredit;
		end
	end

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (sentQ.size() != 0 || releaseQ.size() != 0 || nextCredit)
		begin
			stepCycle();
			waited++;
			if (waited > 400)
				stopOnError("Pipeline did not drain, records or credits still pending");
		end
		checkEqual("instCreditCount", instCreditCount, recordCount);
		checkEqual("sendCredits", sendCredits, kInstDepth);
	endtask

	////////////////////
	// Test sequence
	initial
	begin
		logic [15:0] base;
		logic [4:0] dest;
		int waited;
		void'($urandom(32'hc7d72017));
		for (int k = 0; k < 64; k++)
			delayTable[k] = $urandom_range(3, 0);
		rst = 1'b1;
		instValid = 1'b0;
		instIn = '0;
		holdCredits = 1'b0;
		quietWindow = 1'b0;
		nextCredit = 1'b0;
		prevInstCredit = 1'b0;
		sendCredits = kInstDepth;
		instCreditCount = 0;
		recordCount = 0;
		creditsBack = 0;
		cycleNo = 0;
		lastRelease = 0;
		modelClear();
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		checkEqual("halted", halted, 1'b0);
		checkEqual("retiredCount", retiredCount, 16'd0);
		checkEqual("resValid", resValid, 1'b0);
		checkEqual("instCredit", instCredit, 1'b0);

		repeat (60) sendInst(randAluInst());	// Back-to-back dependencies
		waitDrained();

		// Stores of each size, then every load kind
		for (int n = 0; n < 8; n++)
		begin
			base = 16'($urandom_range(63, 0) * 4);
			sendInst(makeI(kOpSw, 5'd0, pickReg(), base | 16'($urandom_range(3, 0) << 8)));
			sendInst(makeI(kOpSh, 5'd0, pickReg(), base + 16'($urandom_range(1, 0) * 2)));
			sendInst(makeI(kOpSb, 5'd0, pickReg(), base + 16'($urandom_range(3, 0))));
			sendInst(makeI(kOpLw, 5'd0, pickReg(), base));
			sendInst(makeI(kOpLwu, 5'd0, pickReg(), base));
			sendInst(makeI(kOpLh, 5'd0, pickReg(), base + 16'($urandom_range(1, 0) * 2)));
			sendInst(makeI(kOpLhu, 5'd0, pickReg(), base + 16'($urandom_range(1, 0) * 2)));
			sendInst(makeI(kOpLbu, 5'd0, pickReg(), base + 16'($urandom_range(3, 0))));
			dest = 5'($urandom_range(7, 1));
			sendInst(makeI(kOpLb, 5'd0, dest, base + 16'($urandom_range(3, 0))));
			sendInst(makeR(kFnAdd, dest, dest, pickReg(), 5'd0));	// Load-use forward
		end
		waitDrained();

		for (int n = 0; n < 24; n++)
		begin
			dest = pickReg();
			base = 16'($urandom);
			if (n % 2 == 0)
				sendInst(makeI(kOpBeq, dest, (n % 4 == 0) ? dest : pickReg(), base));
			else
				sendInst(makeI(kOpBne, dest, (n % 4 == 1) ? dest : pickReg(), base));
			if (n % 3 == 0)
				sendInst(randAluInst());	// Keep register values moving
		end
		waitDrained();

		// Sink withholds credits, issue must stop at the limit
		holdCredits = 1'b1;
		repeat (6) sendInst(randAluInst());
		waited = 0;
		while (recordCount - creditsBack < kResCredits)
		begin
			stepCycle();
			waited++;
			if (waited > 200)
				stopOnError("Records stalled before result credits ran out");
		end
		repeat (20) stepCycle();
		checkEqual("outstanding records", recordCount - creditsBack, kResCredits);
		checkEqual("queued instructions", sentQ.size(), 2);
		checkEqual("instCreditCount", instCreditCount, recordCount);
		holdCredits = 1'b0;
		waitDrained();

		sendInst(makeI(kOpEnd, 5'd0, 5'd0, 16'h0000));
		repeat (3) sendInst(randAluInst());
		waited = 0;
		while (!halted)
		begin
			stepCycle();
			waited++;
			if (waited > 200)
				stopOnError("Halt flag never rose after END was sent");
		end
		repeat (3) stepCycle();	// Stage 1 leftovers retire
		quietWindow = 1'b1;
		repeat (50) stepCycle();
		quietWindow = 1'b0;
		checkEqual("halted", halted, 1'b1);
		checkEqual("retiredCount", retiredCount, 16'(recordCount));
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+bench
src/mipsPkg.sv
src/creditFifo.sv
src/controlUnit.sv
src/regFile.sv
src/aluUnit.sv
src/dataMem.sv
src/execPipe.sv
src/statusRegs.sv
src/coreTop.sv
bench/coreTb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - src/mipsPkg.sv
  - src/creditFifo.sv
  - src/controlUnit.sv
  - src/regFile.sv
  - src/aluUnit.sv
  - src/dataMem.sv
  - src/execPipe.sv
  - src/statusRegs.sv
  - src/coreTop.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/coreTb.sv
